// ==== project.f ====
+incdir+rtl
rtl/cia_reg_pkg.sv
rtl/cia_timer_pkg.sv
rtl/cia_timer_if.sv
rtl/cia_reg_decode.sv
rtl/cia_interval_timer.sv
rtl/cia_irq_readback.sv
rtl/cia_top.sv
test/cia_tb_checks.sv
test/cia_tb.sv

// ==== rtl/cia_config.svh ====
// CIA core configuration
// Reset values of the timer latches and the I/O ports, and the
// number of interrupt sources

`ifndef CIA_CONFIG_SVH
`define CIA_CONFIG_SVH

// Timer latch after reset
`define CIA_LATCH_RESET 16'hffff

// Port data and direction registers after reset
`define CIA_PORT_RESET (8'h00)
`define CIA_DDR_RESET (8'h00)

`define CIA_NUM_IRQ 5

`endif

// ==== rtl/cia_interval_timer.sv ====
// CIA interval timer
// 16-bit down-counter with latch reload, one-shot stop, force load
// and a selectable count source, plus the PB toggle flip-flop

`timescale 1ns/1ps

module cia_interval_timer (
  input  logic       clk,
  input  logic       int_reset,
  input  logic       phi2,
  input  logic       ta_underflow,
  input  logic       cnt_in,
  cia_timer_if.timer tbus
);

  logic [15:0] count;
  logic        cnt_q;
  logic        cnt_edge;
  logic        src_active;
  logic        tick;
  logic        underflow;
  logic        start_q;
  logic        load_pend;
  logic        toggle_ff;

  // CNT is sampled once per phi2 cycle
  assign cnt_edge = cnt_in && !cnt_q;

  always_comb begin
    case (tbus.src)
      cia_timer_pkg::SRC_PHI2:             src_active = 1'b1;
      cia_timer_pkg::SRC_CNT_EDGE:         src_active = cnt_edge;
      cia_timer_pkg::SRC_TA_UNDERFLOW:     src_active = ta_underflow;
      cia_timer_pkg::SRC_TA_UNDERFLOW_CNT: src_active = ta_underflow && cnt_in;
      default:                             src_active = 1'b0;
    endcase
  end

  assign tick      = phi2 && tbus.start && src_active;
  assign underflow = tick && count == 16'h0000;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      count     <= 16'h0000;
      cnt_q     <= 1'b0;
      start_q   <= 1'b0;
      load_pend <= 1'b0;
      toggle_ff <= 1'b0;
    end else begin
      if (tbus.load_strobe) load_pend <= 1'b1;
      if (phi2) begin
        cnt_q   <= cnt_in;
        start_q <= tbus.start;
        if (tbus.start && !start_q) toggle_ff <= 1'b1;
        if (underflow) toggle_ff <= ~toggle_ff;
        if (underflow || load_pend) begin
          count     <= tbus.latch;
          load_pend <= 1'b0;
        end else if (tick) begin
          count <= count - 16'd1;
        end
      end
      // High byte write while stopped
      if (tbus.hi_write && !tbus.start) count <= tbus.latch;
    end
  end

  assign tbus.count       = count;
  assign tbus.underflow   = underflow;
  assign tbus.clear_start = underflow && tbus.one_shot;
  assign tbus.toggle_ff   = toggle_ff;

  a_reload_after_underflow: assert property (@(posedge clk) disable iff (int_reset)
    underflow |=> count == $past(tbus.latch));

endmodule

// ==== rtl/cia_irq_readback.sv ====
// CIA interrupt control and read-back
// Keeps the ICR flags and mask, drives irq_n and registers the read
// data for the register selected on the bus

`timescale 1ns/1ps
`include "cia_config.svh"

module cia_irq_readback (
  input  logic                    clk,
  input  logic                    int_reset,
  input  logic                    phi2,
  input  logic                    cs_n,
  input  logic                    rw,
  input  logic [3:0]              rs,
  input  logic [7:0]              pa_in,
  input  logic [7:0]              pb_in,
  input  logic                    mask_wr,
  input  logic [7:0]              mask_data,
  cia_timer_if.readback           ta_bus,
  cia_timer_if.readback           tb_bus,
  output logic [7:0]              db_out,
  output logic                    irq_n
);

  cia_reg_pkg::reg_addr_e     addr;
  logic                       rd;
  logic                       icr_read_clear;
  logic [`CIA_NUM_IRQ-1:0]    flags;
  logic [`CIA_NUM_IRQ-1:0]    mask;
  logic [`CIA_NUM_IRQ-1:0]    src_hit;

  assign addr = cia_reg_pkg::reg_addr_e'(rs);
  assign rd   = !cs_n && rw;

  // TOD alarm, serial port and FLAG pin are not present
  always_comb begin
    src_hit                            = '0;
    src_hit[cia_timer_pkg::IRQ_TA]     = ta_bus.underflow;
    src_hit[cia_timer_pkg::IRQ_TB]     = tb_bus.underflow;
    src_hit[cia_timer_pkg::IRQ_ALARM]  = 1'b0;
    src_hit[cia_timer_pkg::IRQ_SERIAL] = 1'b0;
    src_hit[cia_timer_pkg::IRQ_FLAG]   = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      icr_read_clear <= 1'b0;
      flags          <= '0;
      mask           <= '0;
      irq_n          <= 1'b1;
    end else begin
      icr_read_clear <= rd && addr == cia_reg_pkg::REG_ICR;
      // A new event in the clearing cycle is kept
      flags <= (icr_read_clear ? '0 : flags) | src_hit;
      if (mask_wr) begin
        mask <= mask_data[7] ? (mask | mask_data[`CIA_NUM_IRQ-1:0]) :
                               (mask & ~mask_data[`CIA_NUM_IRQ-1:0]);
      end
      if (icr_read_clear) irq_n <= 1'b1;
      else if (phi2 && |(flags & mask)) irq_n <= 1'b0;
    end
  end

  // Read data, direction registers are write-only here
  always_ff @(posedge clk) begin
    if (int_reset) begin
      db_out <= 8'h00;
    end else if (rd) begin
      case (addr)
        cia_reg_pkg::REG_PRA:   db_out <= pa_in;
        cia_reg_pkg::REG_PRB:   db_out <= pb_in;
        cia_reg_pkg::REG_TA_LO: db_out <= ta_bus.count[7:0];
        cia_reg_pkg::REG_TA_HI: db_out <= ta_bus.count[15:8];
        cia_reg_pkg::REG_TB_LO: db_out <= tb_bus.count[7:0];
        cia_reg_pkg::REG_TB_HI: db_out <= tb_bus.count[15:8];
        cia_reg_pkg::REG_ICR:   db_out <= {~irq_n, {(7 - `CIA_NUM_IRQ){1'b0}}, flags};
        cia_reg_pkg::REG_CRA:
          db_out <= {2'b00, ta_bus.src[0], 1'b0, ta_bus.one_shot,
                     ta_bus.out_toggle, ta_bus.pb_on, ta_bus.start};
        cia_reg_pkg::REG_CRB:
          db_out <= {1'b0, tb_bus.src, 1'b0, tb_bus.one_shot,
                     tb_bus.out_toggle, tb_bus.pb_on, tb_bus.start};
        default:                db_out <= 8'h00;
      endcase
    end
  end

  a_irq_released: assert property (@(posedge clk) disable iff (int_reset)
    icr_read_clear |=> irq_n);

endmodule

// ==== rtl/cia_reg_decode.sv ====
// CIA register write decode
// Holds the port, direction, timer latch and control registers and
// drives the port pins, with optional timer output on PB6 and PB7

`timescale 1ns/1ps
`include "cia_config.svh"

module cia_reg_decode (
  input  logic        clk,
  input  logic        int_reset,
  input  logic        phi2,
  input  logic        cs_n,
  input  logic        rw,
  input  logic [3:0]  rs,
  input  logic [7:0]  db_in,
  output logic [7:0]  pa_out,
  output logic [7:0]  pb_out,
  cia_timer_if.decode ta_bus,
  cia_timer_if.decode tb_bus,
  output logic        mask_wr,
  output logic [7:0]  mask_data
);

  cia_reg_pkg::reg_addr_e    addr;
  logic                      wr;
  logic                      wr_q;
  logic                      wr_first;
  logic [7:0]                pra;
  logic [7:0]                prb;
  logic [7:0]                ddra;
  logic [7:0]                ddrb;
  logic [15:0]               ta_latch;
  logic [15:0]               tb_latch;
  logic [3:0]                cra;
  logic [3:0]                crb;
  cia_timer_pkg::timer_src_e ta_src;
  cia_timer_pkg::timer_src_e tb_src;
  logic                      ta_load;
  logic                      tb_load;
  logic                      ta_hi_wr;
  logic                      tb_hi_wr;
  // Index 0 is timer A, index 1 is timer B
  logic [1:0]                start_now;
  logic [1:0]                tog_now;
  logic [1:0]                tog_q;
  logic [1:0]                run_q;
  logic [1:0]                rise_q;
  logic [1:0]                tmr_pulse;

  assign addr     = cia_reg_pkg::reg_addr_e'(rs);
  assign wr       = !cs_n && !rw;
  assign wr_first = wr && !wr_q;

  // Register writes, strobes only on the first cycle of an access
  always_ff @(posedge clk) begin
    if (int_reset) begin
      wr_q     <= 1'b0;
      pra      <= `CIA_PORT_RESET;
      prb      <= `CIA_PORT_RESET;
      ddra     <= `CIA_DDR_RESET;
      ddrb     <= `CIA_DDR_RESET;
      ta_latch <= `CIA_LATCH_RESET;
      tb_latch <= `CIA_LATCH_RESET;
      cra      <= 4'h0;
      crb      <= 4'h0;
      ta_src   <= cia_timer_pkg::SRC_PHI2;
      tb_src   <= cia_timer_pkg::SRC_PHI2;
      ta_load  <= 1'b0;
      tb_load  <= 1'b0;
      ta_hi_wr <= 1'b0;
      tb_hi_wr <= 1'b0;
      mask_wr  <= 1'b0;
    end else begin
      wr_q     <= wr;
      ta_load  <= wr_first && addr == cia_reg_pkg::REG_CRA && db_in[cia_reg_pkg::CR_FORCE_LOAD];
      tb_load  <= wr_first && addr == cia_reg_pkg::REG_CRB && db_in[cia_reg_pkg::CR_FORCE_LOAD];
      ta_hi_wr <= wr_first && addr == cia_reg_pkg::REG_TA_HI;
      tb_hi_wr <= wr_first && addr == cia_reg_pkg::REG_TB_HI;
      mask_wr  <= wr_first && addr == cia_reg_pkg::REG_ICR;
      // One-shot stop, a CPU write in the same cycle wins
      if (ta_bus.clear_start) cra[cia_reg_pkg::CR_START] <= 1'b0;
      if (tb_bus.clear_start) crb[cia_reg_pkg::CR_START] <= 1'b0;
      if (wr) begin
        case (addr)
          cia_reg_pkg::REG_PRA:   pra             <= db_in;
          cia_reg_pkg::REG_PRB:   prb             <= db_in;
          cia_reg_pkg::REG_DDRA:  ddra            <= db_in;
          cia_reg_pkg::REG_DDRB:  ddrb            <= db_in;
          cia_reg_pkg::REG_TA_LO: ta_latch[7:0]   <= db_in;
          cia_reg_pkg::REG_TA_HI: ta_latch[15:8]  <= db_in;
          cia_reg_pkg::REG_TB_LO: tb_latch[7:0]   <= db_in;
          cia_reg_pkg::REG_TB_HI: tb_latch[15:8]  <= db_in;
          cia_reg_pkg::REG_CRA: begin
            cra    <= db_in[3:0];
            // Timer A has no cascade input
            ta_src <= cia_timer_pkg::timer_src_e'({1'b0, db_in[cia_reg_pkg::CR_INMODE]});
          end
          cia_reg_pkg::REG_CRB: begin
            crb    <= db_in[3:0];
            tb_src <= cia_timer_pkg::timer_src_e'(db_in[cia_reg_pkg::CR_INMODE +: 2]);
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_first && addr == cia_reg_pkg::REG_ICR) mask_data <= db_in;
  end

  assign ta_bus.latch       = ta_latch;
  assign ta_bus.start       = cra[cia_reg_pkg::CR_START];
  assign ta_bus.one_shot    = cra[cia_reg_pkg::CR_ONE_SHOT];
  assign ta_bus.load_strobe = ta_load;
  assign ta_bus.hi_write    = ta_hi_wr;
  assign ta_bus.src         = ta_src;
  assign ta_bus.pb_on       = cra[cia_reg_pkg::CR_PB_ON];
  assign ta_bus.out_toggle  = cra[cia_reg_pkg::CR_OUT_TOGGLE];

  assign tb_bus.latch       = tb_latch;
  assign tb_bus.start       = crb[cia_reg_pkg::CR_START];
  assign tb_bus.one_shot    = crb[cia_reg_pkg::CR_ONE_SHOT];
  assign tb_bus.load_strobe = tb_load;
  assign tb_bus.hi_write    = tb_hi_wr;
  assign tb_bus.src         = tb_src;
  assign tb_bus.pb_on       = crb[cia_reg_pkg::CR_PB_ON];
  assign tb_bus.out_toggle  = crb[cia_reg_pkg::CR_OUT_TOGGLE];

  // Pulse mode sees an underflow as a change of toggle_ff; the set at start is not a pulse
  assign start_now = {crb[cia_reg_pkg::CR_START], cra[cia_reg_pkg::CR_START]};
  assign tog_now   = {tb_bus.toggle_ff, ta_bus.toggle_ff};
  assign tmr_pulse = (tog_now ^ tog_q) & ~rise_q;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pa_out <= `CIA_PORT_RESET | ~`CIA_DDR_RESET;
      pb_out <= `CIA_PORT_RESET | ~`CIA_DDR_RESET;
      tog_q  <= 2'b00;
      run_q  <= 2'b00;
      rise_q <= 2'b00;
    end else if (phi2) begin
      tog_q       <= tog_now;
      run_q       <= start_now;
      rise_q      <= start_now & ~run_q;
      pa_out      <= pra | ~ddra;
      pb_out[5:0] <= prb[5:0] | ~ddrb[5:0];
      pb_out[6]   <= cra[cia_reg_pkg::CR_PB_ON] ?
                     (cra[cia_reg_pkg::CR_OUT_TOGGLE] ? tog_now[0] : tmr_pulse[0]) :
                     (prb[6] | ~ddrb[6]);
      pb_out[7]   <= crb[cia_reg_pkg::CR_PB_ON] ?
                     (crb[cia_reg_pkg::CR_OUT_TOGGLE] ? tog_now[1] : tmr_pulse[1]) :
                     (prb[7] | ~ddrb[7]);
    end
  end

  // A force load is a single clk request, held by the timer until phi2
  a_ta_load_single: assert property (@(posedge clk) disable iff (int_reset)
    ta_bus.load_strobe |=> !ta_bus.load_strobe);
  a_tb_load_single: assert property (@(posedge clk) disable iff (int_reset)
    tb_bus.load_strobe |=> !tb_bus.load_strobe);

endmodule

// ==== rtl/cia_reg_pkg.sv ====
// CIA register map
// Register select encoding and the bit positions inside the timer
// control registers CRA and CRB

package cia_reg_pkg;

  typedef enum logic [3:0] {
    REG_PRA       = 4'h0,
    REG_PRB       = 4'h1,
    REG_DDRA      = 4'h2,
    REG_DDRB      = 4'h3,
    REG_TA_LO     = 4'h4,
    REG_TA_HI     = 4'h5,
    REG_TB_LO     = 4'h6,
    REG_TB_HI     = 4'h7,
    REG_TOD_10THS = 4'h8,
    REG_TOD_SEC   = 4'h9,
    REG_TOD_MIN   = 4'ha,
    REG_TOD_HR    = 4'hb,
    REG_SDR       = 4'hc,
    REG_ICR       = 4'hd,
    REG_CRA       = 4'he,
    REG_CRB       = 4'hf
  } reg_addr_e;

  // Control register fields
  localparam int CR_START      = 0;
  localparam int CR_PB_ON      = 1;
  localparam int CR_OUT_TOGGLE = 2;
  localparam int CR_ONE_SHOT   = 3;
  localparam int CR_FORCE_LOAD = 4;
  // Low bit of the input mode field, one bit in CRA and two in CRB
  localparam int CR_INMODE     = 5;

endpackage

// ==== rtl/cia_timer_if.sv ====
// Timer link
// Latch, control and status of one interval timer, shared by the
// register decode, the timer itself and the read-back logic

`timescale 1ns/1ps

interface cia_timer_if;

  logic [15:0]               latch;
  logic                      start;
  logic                      one_shot;
  logic                      load_strobe;
  logic                      hi_write;
  cia_timer_pkg::timer_src_e src;
  logic                      pb_on;
  logic                      out_toggle;
  logic                      clear_start;
  logic [15:0]               count;
  logic                      underflow;
  logic                      toggle_ff;

  modport decode (
    output latch, start, one_shot, load_strobe, hi_write, src, pb_on, out_toggle,
    input  clear_start, toggle_ff
  );

  modport timer (
    input  latch, start, one_shot, load_strobe, hi_write, src,
    output count, underflow, clear_start, toggle_ff
  );

  modport readback (
    input count, underflow, start, one_shot, src, pb_on, out_toggle
  );

endinterface

// ==== rtl/cia_timer_pkg.sv ====
// CIA timer and interrupt types
// Count source selection and interrupt flag positions

package cia_timer_pkg;

  // Matches the CRB input mode field
  typedef enum logic [1:0] {
    SRC_PHI2             = 2'd0,
    SRC_CNT_EDGE         = 2'd1,
    SRC_TA_UNDERFLOW     = 2'd2,
    SRC_TA_UNDERFLOW_CNT = 2'd3
  } timer_src_e;

  // Bit index in the ICR flag and mask registers
  typedef enum logic [2:0] {
    IRQ_TA     = 3'd0,
    IRQ_TB     = 3'd1,
    IRQ_ALARM  = 3'd2,
    IRQ_SERIAL = 3'd3,
    IRQ_FLAG   = 3'd4
  } irq_src_e;

endpackage

// ==== rtl/cia_top.sv ====
// CIA core top level
// Register decode, timers A and B and the interrupt and read-back
// block, with the CPU bus and the port pins as plain ports

`timescale 1ns/1ps

module cia_top (
  input  logic       clk,
  input  logic       int_reset,
  input  logic       phi2,
  input  logic       cs_n,
  input  logic       rw,
  input  logic [3:0] rs,
  input  logic [7:0] db_in,
  input  logic [7:0] pa_in,
  input  logic [7:0] pb_in,
  input  logic       cnt_in,
  output logic [7:0] db_out,
  output logic [7:0] pa_out,
  output logic [7:0] pb_out,
  output logic       irq_n
);

  logic       mask_wr;
  logic [7:0] mask_data;

  cia_timer_if ta_bus ();
  cia_timer_if tb_bus ();

  cia_reg_decode u_decode (
    .clk       (clk),
    .int_reset (int_reset),
    .phi2      (phi2),
    .cs_n      (cs_n),
    .rw        (rw),
    .rs        (rs),
    .db_in     (db_in),
    .pa_out    (pa_out),
    .pb_out    (pb_out),
    .ta_bus    (ta_bus.decode),
    .tb_bus    (tb_bus.decode),
    .mask_wr   (mask_wr),
    .mask_data (mask_data)
  );

  // Timer A has no cascade source
  cia_interval_timer timer_a (
    .clk          (clk),
    .int_reset    (int_reset),
    .phi2         (phi2),
    .ta_underflow (1'b0),
    .cnt_in       (cnt_in),
    .tbus         (ta_bus.timer)
  );

  cia_interval_timer timer_b (
    .clk          (clk),
    .int_reset    (int_reset),
    .phi2         (phi2),
    .ta_underflow (ta_bus.underflow),
    .cnt_in       (cnt_in),
    .tbus         (tb_bus.timer)
  );

  cia_irq_readback u_readback (
    .clk       (clk),
    .int_reset (int_reset),
    .phi2      (phi2),
    .cs_n      (cs_n),
    .rw        (rw),
    .rs        (rs),
    .pa_in     (pa_in),
    .pb_in     (pb_in),
    .mask_wr   (mask_wr),
    .mask_data (mask_data),
    .ta_bus    (ta_bus.readback),
    .tb_bus    (tb_bus.readback),
    .db_out    (db_out),
    .irq_n     (irq_n)
  );

endmodule

// ==== test/cia_tb.sv ====
// CIA core testbench
// Drives the CPU bus through ports, timers, interrupts, one-shot
// and cascade modes and reports the error count

`timescale 1ns/1ps

module cia_tb;

  localparam int WAIT_LIMIT = 4000;

  logic       clk;
  logic       int_reset;
  logic       phi2;
  logic       cs_n;
  logic       rw;
  logic [3:0] rs;
  logic [7:0] db_in;
  logic [7:0] pa_in;
  logic [7:0] pb_in;
  logic       cnt_in;
  wire  [7:0] db_out;
  wire  [7:0] pa_out;
  wire  [7:0] pb_out;
  wire        irq_n;
  logic       period_en;
  logic       quiet_en;
  int         exp_period;
  int         errors;
  int         phase;
  int         n_lat;
  int         m_lat;
  int         base;
  logic [7:0] rd_data;
  logic [7:0] pra;
  logic [7:0] ddra;
  logic [7:0] prb;
  logic [7:0] ddrb;
  logic [7:0] exp_port;

  cia_top dut0 (
    .clk(clk), .int_reset(int_reset), .phi2(phi2), .cs_n(cs_n), .rw(rw), .rs(rs),
    .db_in(db_in), .pa_in(pa_in), .pb_in(pb_in), .cnt_in(cnt_in),
    .db_out(db_out), .pa_out(pa_out), .pb_out(pb_out), .irq_n(irq_n)
  );

  cia_tb_checks checks0 (
    .clk(clk), .int_reset(int_reset), .phi2(phi2), .db_out(db_out), .pa_out(pa_out),
    .pb_out(pb_out), .irq_n(irq_n), .period_en(period_en), .exp_period(exp_period),
    .quiet_en(quiet_en)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Phi2 strobe one clk in four
  initial begin
    phase = 0;
    phi2  = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      phi2  = (phase == 3);
      phase = (phase + 1) % 4;
    end
  end

  initial begin
    #2000000;
    $display("Simulation did not finish in time");
    $display("Done: errors found");
    $finish;
  end

  task automatic note_timeout(input string what);
    errors++;
    $display("%0t Timed out waiting for %s", $time, what);
  endtask

  task automatic expect_equal(input string name, input int exp, input int act);
    assert (exp == act) else begin
      errors++;
      $display("MISMATCH %0t %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  // Returns just after a phi2 edge, so the next edge is not one
  task automatic align_to_phi2();
    int t;
    t = 0;
    @(posedge clk);
    while (!phi2 && t < WAIT_LIMIT) begin
      @(posedge clk);
      t++;
    end
    if (!phi2) note_timeout("phi2");
    #1;
  endtask

  task automatic wait_phi2_cycles(input int n);
    repeat (n) align_to_phi2();
  endtask

  task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
    align_to_phi2();
    cs_n  = 1'b0;
    rw    = 1'b0;
    rs    = addr;
    db_in = data;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    rw   = 1'b1;
  endtask

  task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
    align_to_phi2();
    cs_n = 1'b0;
    rw   = 1'b1;
    rs   = addr;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    data = db_out;
  endtask

  task automatic wait_toggles(input int target);
    int t;
    t = 0;
    while (checks0.toggle_count < target && t < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (checks0.toggle_count < target) note_timeout("pb_out[6] toggles");
  endtask

  task automatic wait_irq_low();
    int t;
    t = 0;
    while (irq_n && t < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (irq_n) note_timeout("irq_n to fall");
  endtask

  initial begin
    int_reset  = 1'b1;
    cs_n       = 1'b1;
    rw         = 1'b1;
    rs         = 4'h0;
    db_in      = 8'h00;
    pa_in      = 8'h00;
    pb_in      = 8'h00;
    cnt_in     = 1'b0;
    period_en  = 1'b0;
    quiet_en   = 1'b0;
    exp_period = 0;
    errors     = 0;
    void'($urandom(32'h5aa2));
    repeat (10) @(posedge clk);
    #1;
    int_reset = 1'b0;
    expect_equal("irq_n", 1, irq_n);
    expect_equal("db_out", 8'h00, db_out);
    expect_equal("pa_out", 8'hff, pa_out);
    expect_equal("pb_out", 8'hff, pb_out);

    // Ports
    pra   = $urandom;
    ddra  = $urandom;
    prb   = $urandom;
    ddrb  = $urandom;
    pa_in = $urandom;
    pb_in = $urandom;
    bus_write(cia_reg_pkg::REG_PRA, pra);
    bus_write(cia_reg_pkg::REG_DDRA, ddra);
    bus_write(cia_reg_pkg::REG_PRB, prb);
    bus_write(cia_reg_pkg::REG_DDRB, ddrb);
    wait_phi2_cycles(2);
    exp_port = pra | ~ddra;
    expect_equal("pa_out", exp_port, pa_out);
    exp_port = prb | ~ddrb;
    expect_equal("pb_out", exp_port, pb_out);
    bus_read(cia_reg_pkg::REG_PRA, rd_data);
    expect_equal("db_out PRA", pa_in, rd_data);

    // Continuous timer A with toggle on PB6
    n_lat = $urandom_range(20, 3);
    bus_write(cia_reg_pkg::REG_TA_LO, n_lat[7:0]);
    bus_write(cia_reg_pkg::REG_TA_HI, 8'h00);
    exp_period = n_lat + 1;
    period_en  = 1'b1;
    base       = checks0.toggle_count;
    bus_write(cia_reg_pkg::REG_CRA, 8'h07);
    repeat (6) begin
      bus_read(cia_reg_pkg::REG_TA_LO, rd_data);
      assert (rd_data <= n_lat) else begin
        errors++;
        $display("MISMATCH %0t timer A count expected <= %0d got %0d", $time, n_lat, rd_data);
      end
      bus_read(cia_reg_pkg::REG_TA_HI, rd_data);
      expect_equal("timer A count high", 0, rd_data);
      wait_phi2_cycles(1);
    end
    wait_toggles(base + 5);
    period_en = 1'b0;
    bus_write(cia_reg_pkg::REG_CRA, 8'h00);

    // Interrupt flag and mask
    bus_read(cia_reg_pkg::REG_ICR, rd_data);
    bus_write(cia_reg_pkg::REG_TA_HI, 8'h00);
    bus_write(cia_reg_pkg::REG_CRA, 8'h01);
    wait_phi2_cycles(n_lat + 3);
    expect_equal("irq_n", 1, irq_n);
    bus_read(cia_reg_pkg::REG_ICR, rd_data);
    expect_equal("ICR bit 0", 1, rd_data[0]);
    expect_equal("ICR bit 7", 0, rd_data[7]);
    bus_write(cia_reg_pkg::REG_ICR, 8'h81);
    wait_irq_low();
    bus_read(cia_reg_pkg::REG_ICR, rd_data);
    expect_equal("ICR bit 7", 1, rd_data[7]);
    @(posedge clk);
    #1;
    expect_equal("irq_n", 1, irq_n);
    bus_write(cia_reg_pkg::REG_CRA, 8'h00);
    bus_write(cia_reg_pkg::REG_ICR, 8'h01);
    bus_read(cia_reg_pkg::REG_ICR, rd_data);

    // One-shot with force load
    bus_write(cia_reg_pkg::REG_TA_HI, 8'h00);
    bus_write(cia_reg_pkg::REG_CRA, 8'h1f);
    wait_phi2_cycles(3);
    base = checks0.toggle_count;
    wait_toggles(base + 1);
    wait_phi2_cycles(2);
    bus_read(cia_reg_pkg::REG_CRA, rd_data);
    expect_equal("CRA start", 0, rd_data[0]);
    quiet_en = 1'b1;
    wait_phi2_cycles(3 * (n_lat + 1));
    quiet_en = 1'b0;
    expect_equal("pb_out[6] toggles", base + 1, checks0.toggle_count);

    // Timer B counts timer A underflows
    m_lat = $urandom_range(20, 3);
    bus_write(cia_reg_pkg::REG_TB_LO, m_lat[7:0]);
    bus_write(cia_reg_pkg::REG_TB_HI, 8'h00);
    bus_write(cia_reg_pkg::REG_TA_HI, 8'h00);
    bus_read(cia_reg_pkg::REG_ICR, rd_data);
    bus_write(cia_reg_pkg::REG_ICR, 8'h82);
    bus_write(cia_reg_pkg::REG_CRB, 8'h41);
    bus_write(cia_reg_pkg::REG_CRA, 8'h07);
    wait_phi2_cycles(3);
    base = checks0.toggle_count;
    wait_irq_low();
    wait_phi2_cycles(1);
    expect_equal("pb_out[6] toggles before ICR bit 1", m_lat + 1, checks0.toggle_count - base);
    bus_read(cia_reg_pkg::REG_ICR, rd_data);
    expect_equal("ICR bit 1", 1, rd_data[1]);
    bus_write(cia_reg_pkg::REG_CRA, 8'h00);
    bus_write(cia_reg_pkg::REG_CRB, 8'h00);

    wait_phi2_cycles(2);
    $display("Errors: %0d (testbench %0d, checker %0d)",
             errors + checks0.errors, errors, checks0.errors);
    if (errors + checks0.errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== test/cia_tb_checks.sv ====
// CIA testbench checker
// Models the PB6 toggle spacing in phi2 cycles and checks the port
// outputs with concurrent assertions

`timescale 1ns/1ps

module cia_tb_checks (
  input logic       clk,
  input logic       int_reset,
  input logic       phi2,
  input logic [7:0] db_out,
  input logic [7:0] pa_out,
  input logic [7:0] pb_out,
  input logic       irq_n,
  input logic       period_en,
  input int         exp_period,
  input logic       quiet_en
);

  int   errors = 0;
  int   toggle_count;
  int   gap;
  int   seen;
  logic pb6_q;

  // Phi2 cycles between changes of PB6
  always_ff @(posedge clk) begin
    if (int_reset) begin
      pb6_q        <= 1'b1;
      gap          <= 0;
      toggle_count <= 0;
      seen         <= 0;
    end else begin
      pb6_q <= pb_out[6];
      if (pb_out[6] != pb6_q) begin
        toggle_count <= toggle_count + 1;
        gap          <= 0;
      end else if (phi2) begin
        gap <= gap + 1;
      end
      if (!period_en) seen <= 0;
      else if (pb_out[6] != pb6_q && seen < 3) seen <= seen + 1;
    end
  end

  a_reset_values: assert property (@(posedge clk)
    $fell(int_reset) |-> (irq_n && db_out == 8'h00 && pa_out == 8'hff && pb_out == 8'hff))
  else begin
    errors++;
    $write("MISMATCH %0t reset outputs expected irq_n=1 db_out=00 pa_out=ff pb_out=ff",
           $time);
    $display(" got irq_n=%b db_out=%h pa_out=%h pb_out=%h", $sampled(irq_n),
             $sampled(db_out), $sampled(pa_out), $sampled(pb_out));
  end

  // First changes come from the port value, the start and the first run from the latch
  a_toggle_period: assert property (@(posedge clk) disable iff (int_reset)
    (period_en && seen >= 3 && pb_out[6] != pb6_q) |-> gap == exp_period)
  else begin
    errors++;
    $display("MISMATCH %0t pb_out[6] toggle spacing expected %0d got %0d",
             $time, $sampled(exp_period), $sampled(gap));
  end

  a_no_toggle: assert property (@(posedge clk) disable iff (int_reset)
    quiet_en |-> pb_out[6] == pb6_q)
  else begin
    errors++;
    $display("MISMATCH %0t pb_out[6] expected %b got %b",
             $time, $sampled(pb6_q), $sampled(pb_out[6]));
  end

endmodule
